// ==== verilog/gb_pkg.sv ====
`default_nettype none

package gb_pkg;

	typedef logic [15:0] addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [12:0] vram_adr_t;
	typedef logic [7:0]  oam_adr_t;

	typedef enum logic {
		idle,
		copy
	} dma_state_e;

	localparam byte_t OPEN_BUS    = 8'hff;    // Nobody drives the data lines
	localparam addr_t DMA_REG_ADR = 16'hff46;

	localparam int OAM_BYTES  = 160;
	localparam int VRAM_BYTES = 8192;

	// Region bases, each region ends just below the next one
	localparam addr_t VRAM_BASE     = 16'h8000;  // ROM below
	localparam addr_t XRAM_BASE     = 16'ha000;
	localparam addr_t WRAM_BASE     = 16'hc000;  // E000 up echoes C000
	localparam addr_t OAM_BASE      = 16'hfe00;
	localparam addr_t UNUSABLE_BASE = 16'hfea0;
	localparam addr_t IO_BASE       = 16'hff00;

endpackage

`default_nettype wire

// ==== verilog/gb_memmap.sv ====
`default_nettype none

module gb_memmap (
	input  wire gb_pkg::addr_t adr,
	input  wire                enable,
	output logic               sel_rom,
	output logic               sel_vram,
	output logic               sel_xram,
	output logic               sel_wram,
	output logic               sel_oam,
	output logic               sel_dma_reg
);
	import gb_pkg::*;

	logic in_io;

	assign in_io = adr >= IO_BASE;

	assign sel_rom  = enable && adr < VRAM_BASE;
	assign sel_vram = enable && adr >= VRAM_BASE && adr < XRAM_BASE;
	assign sel_xram = enable && adr >= XRAM_BASE && adr < WRAM_BASE;
	assign sel_wram = enable && adr >= WRAM_BASE && adr < OAM_BASE;  // Mirror included
	assign sel_oam  = enable && adr >= OAM_BASE && adr < UNUSABLE_BASE;

	// Only one IO register lives in this design
	assign sel_dma_reg = enable && in_io && adr[7:0] == DMA_REG_ADR[7:0];

endmodule

`default_nettype wire

// ==== verilog/oam_dma.sv ====
`default_nettype none

module oam_dma (
	input  wire                    gbclk,
	input  wire                    rst,
	input  wire                    reg_wr,
	input  wire gb_pkg::byte_t     reg_din,
	input  wire gb_pkg::byte_t     din,
	output gb_pkg::addr_t          adr,
	output logic                   rd,
	output logic                   oam_wr,
	output logic                   active,
	output gb_pkg::oam_adr_t       oam_adr,
	output gb_pkg::byte_t          dout
);
	import gb_pkg::*;

	localparam oam_adr_t LAST = oam_adr_t'(OAM_BYTES);

	dma_state_e state;
	byte_t      page;
	oam_adr_t   cnt;    // Next source byte

	always_ff @(posedge gbclk) begin
		if (rst) begin
			state  <= idle;
			cnt    <= '0;
			oam_wr <= 1'b0;
		end else begin
			oam_wr <= rd;   // Write trails its read by one cycle
			case (state)
			idle:
				if (reg_wr) begin
					state <= copy;
					cnt   <= '0;
				end
			copy:
				if (cnt == LAST)
					state <= idle;  // Last write done
				else
					cnt <= cnt + 1'b1;
			endcase
		end
	end

	always_ff @(posedge gbclk) begin
		if (state == idle && reg_wr)
			page <= reg_din;
		oam_adr <= cnt;
	end

	assign active = state == copy;
	assign rd     = active && cnt != LAST;
	assign adr    = {page, cnt};
	assign dout   = din;    // Read data arrives in the write cycle

endmodule

`default_nettype wire

// ==== verilog/video_ram.sv ====
`default_nettype none

module video_ram #(
	parameter int DEPTH = gb_pkg::VRAM_BYTES
) (
	input  wire                      gbclk,
	input  wire [$clog2(DEPTH)-1:0]  adr,
	input  wire gb_pkg::byte_t       din,
	input  wire                      rd,
	input  wire                      wr,
	output gb_pkg::byte_t            dout
);
	import gb_pkg::*;

	byte_t mem [DEPTH];

	always_ff @(posedge gbclk) begin
		if (wr)
			mem[adr] <= din;
		if (rd)
			dout <= mem[adr];   // Holds until the next read
	end

endmodule

`default_nettype wire

// ==== verilog/video_arbiter.sv ====
`default_nettype none

module video_arbiter (
	input  wire                    gbclk,
	input  wire                    rst,
	input  wire                    ppu_need_vram,
	input  wire                    ppu_need_oam,
	input  wire                    ppu_rd,
	input  wire gb_pkg::addr_t     ppu_adr,
	input  wire                    dma_active,
	input  wire                    dma_src_vram,
	input  wire                    dma_rd,
	input  wire gb_pkg::addr_t     dma_adr,
	input  wire                    dma_oam_wr,
	input  wire gb_pkg::oam_adr_t  dma_oam_adr,
	input  wire gb_pkg::byte_t     dma_dout,
	input  wire                    cpu_sel_vram,
	input  wire                    cpu_sel_oam,
	input  wire                    cpu_rd,
	input  wire                    cpu_wr,
	input  wire gb_pkg::addr_t     cpu_adr,
	input  wire gb_pkg::byte_t     cpu_dout,
	output logic                   cpu_vram_ok,
	output logic                   cpu_oam_ok,
	output logic                   dma_vram_ok,
	output gb_pkg::byte_t          ppu_data,
	output gb_pkg::byte_t          dma_vram_data,
	output gb_pkg::byte_t          vram_dout,
	output gb_pkg::byte_t          oam_dout
);
	import gb_pkg::*;

	vram_adr_t vram_adr;
	byte_t     vram_din;
	logic      vram_rd, vram_wr;
	oam_adr_t  oam_adr;
	byte_t     oam_din;
	logic      oam_rd, oam_wr;
	logic      dma_on_vram, dma_grant;
	logic      ppu_oam_q, dma_grant_q;

	assign dma_on_vram = dma_active && dma_src_vram;
	assign dma_grant   = dma_on_vram && !ppu_need_vram;
	assign cpu_vram_ok = cpu_sel_vram && !ppu_need_vram && !dma_on_vram;
	assign cpu_oam_ok  = cpu_sel_oam && !ppu_need_oam && !dma_active;

	// PPU first, then DMA, CPU last
	always_comb begin
		vram_adr = cpu_adr[12:0];
		vram_din = cpu_dout;
		vram_rd  = cpu_rd && cpu_vram_ok;
		vram_wr  = cpu_wr && cpu_vram_ok;
		if (ppu_need_vram) begin
			vram_adr = ppu_adr[12:0];
			vram_rd  = ppu_rd;
		end else if (dma_on_vram) begin
			vram_adr = dma_adr[12:0];
			vram_rd  = dma_rd;
		end
	end

	always_comb begin
		oam_adr = cpu_adr[7:0];
		oam_din = cpu_dout;
		oam_rd  = cpu_rd && cpu_oam_ok;
		oam_wr  = cpu_wr && cpu_oam_ok;
		if (ppu_need_oam) begin
			oam_adr = ppu_adr[7:0];
			oam_rd  = ppu_rd;
		end else if (dma_active) begin
			oam_adr = dma_oam_adr;
			oam_din = dma_dout;
			oam_wr  = dma_oam_wr;
		end
	end

	always_ff @(posedge gbclk) begin
		if (rst) begin
			ppu_oam_q   <= 1'b0;
			dma_vram_ok <= 1'b0;
			dma_grant_q <= 1'b0;
		end else begin
			if (ppu_rd)
				ppu_oam_q <= ppu_need_oam;
			dma_vram_ok <= dma_on_vram && dma_rd;   // DMA byte answered from the VRAM side
			dma_grant_q <= dma_grant && dma_rd;
		end
	end

	assign ppu_data      = ppu_oam_q ? oam_dout : vram_dout;
	assign dma_vram_data = dma_grant_q ? vram_dout : OPEN_BUS;

	video_ram #(.DEPTH(VRAM_BYTES)) vram (
		.gbclk(gbclk),
		.adr(vram_adr),
		.din(vram_din),
		.rd(vram_rd),
		.wr(vram_wr),
		.dout(vram_dout)
	);

	video_ram #(.DEPTH(OAM_BYTES)) oam (
		.gbclk(gbclk),
		.adr(oam_adr),
		.din(oam_din),
		.rd(oam_rd),
		.wr(oam_wr),
		.dout(oam_dout)
	);

endmodule

`default_nettype wire

// ==== verilog/ext_bus_port.sv ====
`default_nettype none

module ext_bus_port (
	input  wire                gbclk,
	input  wire                rst,
	input  wire                dma_owns,
	input  wire gb_pkg::addr_t dma_adr,
	input  wire                dma_rd,
	input  wire gb_pkg::addr_t cpu_adr,
	input  wire                cpu_rd,
	input  wire                cpu_wr,
	input  wire gb_pkg::byte_t cpu_dout,
	input  wire                cpu_sel_rom,
	input  wire                cpu_sel_xram,
	input  wire                cpu_sel_wram,
	input  wire                dma_sel_rom,
	input  wire                dma_sel_xram,
	input  wire                dma_sel_wram,
	input  wire gb_pkg::byte_t ext_din,
	output gb_pkg::addr_t      ext_adr,
	output gb_pkg::byte_t      ext_dout,
	output logic               ext_rd,
	output logic               ext_wr,
	output logic               ext_cs_rom,
	output logic               ext_cs_xram,
	output logic               ext_cs_wram,
	output logic               cpu_ext_ok,
	output gb_pkg::byte_t      rd_data
);
	import gb_pkg::*;

	logic cpu_ext, cpu_strobe;

	assign cpu_ext    = cpu_sel_rom || cpu_sel_xram || cpu_sel_wram;
	assign cpu_ext_ok = cpu_ext && !dma_owns;
	assign cpu_strobe = cpu_ext_ok && (cpu_rd || cpu_wr);

	assign ext_adr  = dma_owns ? dma_adr : cpu_adr;
	assign ext_dout = cpu_dout;     // DMA never writes out here
	assign ext_rd   = dma_owns ? dma_rd : cpu_rd && cpu_ext;
	assign ext_wr   = cpu_wr && cpu_ext_ok;

	// Selects only during a strobe
	assign ext_cs_rom  = (dma_sel_rom && dma_rd) || (cpu_sel_rom && cpu_strobe);
	assign ext_cs_xram = (dma_sel_xram && dma_rd) || (cpu_sel_xram && cpu_strobe);
	assign ext_cs_wram = (dma_sel_wram && dma_rd) || (cpu_sel_wram && cpu_strobe);

	always_ff @(posedge gbclk) begin
		if (rst)
			rd_data <= OPEN_BUS;
		else if (ext_rd)
			rd_data <= ext_din;
	end

endmodule

`default_nettype wire

// ==== verilog/cpu_read_mux.sv ====
`default_nettype none

module cpu_read_mux (
	input  wire                gbclk,
	input  wire                rst,
	input  wire                cpu_rd,
	input  wire                cpu_vram_ok,
	input  wire                cpu_oam_ok,
	input  wire                cpu_ext_ok,
	input  wire gb_pkg::byte_t vram_data,
	input  wire gb_pkg::byte_t oam_data,
	input  wire gb_pkg::byte_t ext_data,
	output gb_pkg::byte_t      cpu_din
);
	import gb_pkg::*;

	logic  rd_q, vram_q, oam_q, ext_q;
	byte_t hold_q;
	byte_t fresh;

	always_ff @(posedge gbclk) begin
		if (rst) begin
			rd_q   <= 1'b0;
			vram_q <= 1'b0;
			oam_q  <= 1'b0;
			ext_q  <= 1'b0;
			hold_q <= OPEN_BUS;
		end else begin
			rd_q   <= cpu_rd;
			vram_q <= cpu_rd && cpu_vram_ok;
			oam_q  <= cpu_rd && cpu_oam_ok;
			ext_q  <= cpu_rd && cpu_ext_ok;
			hold_q <= cpu_din;  // Keeps the last answer
		end
	end

	always_comb begin
		fresh = OPEN_BUS;   // Refused or unmapped
		if (vram_q)
			fresh = vram_data;
		else if (oam_q)
			fresh = oam_data;
		else if (ext_q)
			fresh = ext_data;
		cpu_din = rd_q ? fresh : hold_q;
	end

endmodule

`default_nettype wire

// ==== verilog/gb_bus_top.sv ====
`default_nettype none

module gb_bus_top (
	input  wire                gbclk,
	input  wire                rst,
	input  wire gb_pkg::addr_t cpu_adr,
	input  wire gb_pkg::byte_t cpu_dout,
	input  wire                cpu_rd,
	input  wire                cpu_wr,
	output gb_pkg::byte_t      cpu_din,
	input  wire                ppu_need_vram,
	input  wire                ppu_need_oam,
	input  wire gb_pkg::addr_t ppu_adr,
	input  wire                ppu_rd,
	output gb_pkg::byte_t      ppu_data,
	output gb_pkg::addr_t      ext_adr,
	output gb_pkg::byte_t      ext_dout,
	output logic               ext_rd,
	output logic               ext_wr,
	output logic               ext_cs_rom,
	output logic               ext_cs_xram,
	output logic               ext_cs_wram,
	input  wire gb_pkg::byte_t ext_din
);
	import gb_pkg::*;

	logic     cpu_sel_rom, cpu_sel_vram, cpu_sel_xram, cpu_sel_wram;
	logic     cpu_sel_oam, cpu_sel_dma_reg;
	logic     dma_sel_rom, dma_sel_vram, dma_sel_xram, dma_sel_wram;
	addr_t    dma_adr;
	logic     dma_rd, dma_oam_wr, dma_active;
	oam_adr_t dma_oam_adr;
	byte_t    dma_dout;
	logic     cpu_vram_ok, cpu_oam_ok, cpu_ext_ok, dma_vram_ok;
	byte_t    dma_vram_data, vram_dout, oam_dout, ext_rd_data;

	gb_memmap cpu_map (
		.adr(cpu_adr),
		.enable(1'b1),
		.sel_rom(cpu_sel_rom),
		.sel_vram(cpu_sel_vram),
		.sel_xram(cpu_sel_xram),
		.sel_wram(cpu_sel_wram),
		.sel_oam(cpu_sel_oam),
		.sel_dma_reg(cpu_sel_dma_reg)
	);

	gb_memmap dma_map (
		.adr(dma_adr),
		.enable(dma_active),
		.sel_rom(dma_sel_rom),
		.sel_vram(dma_sel_vram),
		.sel_xram(dma_sel_xram),
		.sel_wram(dma_sel_wram),
		.sel_oam(),
		.sel_dma_reg()
	);

	oam_dma dma (
		.gbclk(gbclk),
		.rst(rst),
		.reg_wr(cpu_wr && cpu_sel_dma_reg),
		.reg_din(cpu_dout),
		.din(dma_vram_ok ? dma_vram_data : ext_rd_data),  // Source of the byte in flight
		.adr(dma_adr),
		.rd(dma_rd),
		.oam_wr(dma_oam_wr),
		.active(dma_active),
		.oam_adr(dma_oam_adr),
		.dout(dma_dout)
	);

	video_arbiter video (
		.gbclk(gbclk),
		.rst(rst),
		.ppu_need_vram(ppu_need_vram),
		.ppu_need_oam(ppu_need_oam),
		.ppu_rd(ppu_rd),
		.ppu_adr(ppu_adr),
		.dma_active(dma_active),
		.dma_src_vram(dma_sel_vram),
		.dma_rd(dma_rd),
		.dma_adr(dma_adr),
		.dma_oam_wr(dma_oam_wr),
		.dma_oam_adr(dma_oam_adr),
		.dma_dout(dma_dout),
		.cpu_sel_vram(cpu_sel_vram),
		.cpu_sel_oam(cpu_sel_oam),
		.cpu_rd(cpu_rd),
		.cpu_wr(cpu_wr),
		.cpu_adr(cpu_adr),
		.cpu_dout(cpu_dout),
		.cpu_vram_ok(cpu_vram_ok),
		.cpu_oam_ok(cpu_oam_ok),
		.dma_vram_ok(dma_vram_ok),
		.ppu_data(ppu_data),
		.dma_vram_data(dma_vram_data),
		.vram_dout(vram_dout),
		.oam_dout(oam_dout)
	);

	ext_bus_port ext (
		.gbclk(gbclk),
		.rst(rst),
		.dma_owns(dma_sel_rom || dma_sel_xram || dma_sel_wram),
		.dma_adr(dma_adr),
		.dma_rd(dma_rd),
		.cpu_adr(cpu_adr),
		.cpu_rd(cpu_rd),
		.cpu_wr(cpu_wr),
		.cpu_dout(cpu_dout),
		.cpu_sel_rom(cpu_sel_rom),
		.cpu_sel_xram(cpu_sel_xram),
		.cpu_sel_wram(cpu_sel_wram),
		.dma_sel_rom(dma_sel_rom),
		.dma_sel_xram(dma_sel_xram),
		.dma_sel_wram(dma_sel_wram),
		.ext_din(ext_din),
		.ext_adr(ext_adr),
		.ext_dout(ext_dout),
		.ext_rd(ext_rd),
		.ext_wr(ext_wr),
		.ext_cs_rom(ext_cs_rom),
		.ext_cs_xram(ext_cs_xram),
		.ext_cs_wram(ext_cs_wram),
		.cpu_ext_ok(cpu_ext_ok),
		.rd_data(ext_rd_data)
	);

	cpu_read_mux rd_mux (
		.gbclk(gbclk),
		.rst(rst),
		.cpu_rd(cpu_rd),
		.cpu_vram_ok(cpu_vram_ok),
		.cpu_oam_ok(cpu_oam_ok),
		.cpu_ext_ok(cpu_ext_ok),
		.vram_data(vram_dout),
		.oam_data(oam_dout),
		.ext_data(ext_rd_data),
		.cpu_din(cpu_din)
	);

endmodule

`default_nettype wire

// ==== tests/tb_models.svh ====
`ifndef TB_MODELS_SVH
`define TB_MODELS_SVH

byte_t vram_m [8192];   // Last value the CPU wrote per VRAM offset
byte_t oam_m [160];

int    checks;
int    errors;
int    test_errors;
string test_name;

// Regions of the CPU address map
localparam int REG_ROM  = 0;
localparam int REG_VRAM = 1;
localparam int REG_XRAM = 2;
localparam int REG_WRAM = 3;
localparam int REG_OAM  = 4;
localparam int REG_NONE = 5;    // Unusable space and IO

// What the external memories return for an address
function automatic byte_t ext_rule(input addr_t a);
	return a[7:0] ^ a[15:8];
endfunction

function automatic int region_of(input addr_t a);
	if (a <= 16'h7fff)
		return REG_ROM;
	if (a <= 16'h9fff)
		return REG_VRAM;
	if (a <= 16'hbfff)
		return REG_XRAM;
	if (a <= 16'hfdff)
		return REG_WRAM;    // Echo area too
	if (a <= 16'hfe9f)
		return REG_OAM;
	return REG_NONE;
endfunction

function automatic logic is_ext(input int region);
	return region == REG_ROM || region == REG_XRAM || region == REG_WRAM;
endfunction

task automatic check_byte(input string what, input byte_t exp, input byte_t act);
	checks++;
	if (act !== exp) begin
		errors++;
		test_errors++;
		$display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
	end
endtask

task automatic check_addr(input string what, input addr_t exp, input addr_t act);
	checks++;
	if (act !== exp) begin
		errors++;
		test_errors++;
		$display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
	end
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
	checks++;
	if (act !== exp) begin
		errors++;
		test_errors++;
		$display("Error %s %s: expected %b, actual %b", test_name, what, exp, act);
	end
endtask

task automatic check_count(input string what, input int exp, input int act);
	checks++;
	if (act != exp) begin
		errors++;
		test_errors++;
		$display("Error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
	end
endtask

`endif

// ==== tests/tb_gb_bus.sv ====
`default_nettype none

module tb_gb_bus;
	timeunit 1ns;
	timeprecision 1ps;
	import gb_pkg::*;

	localparam int PERIOD     = 20;
	localparam int T_DECODE   = 200 * 5;
	localparam int T_ONCHIP   = 128 * 3;
	localparam int T_PPU      = 160 * 3;
	localparam int T_DMA_EXT  = 170 + 20 * 3 + 160 * 3;
	localparam int T_DMA_VRAM = 160 * 3 + 170 + 20 * 3 + 160 * 3;
	localparam int WATCHDOG_CYCLES = T_DECODE + T_ONCHIP + T_PPU + T_DMA_EXT + T_DMA_VRAM + 500;

	logic  gbclk = 1'b0;
	logic  rst;
	addr_t cpu_adr;
	byte_t cpu_dout;
	logic  cpu_rd, cpu_wr;
	byte_t cpu_din;
	logic  ppu_need_vram, ppu_need_oam, ppu_rd;
	addr_t ppu_adr;
	byte_t ppu_data;
	addr_t ext_adr;
	byte_t ext_dout;
	logic  ext_rd, ext_wr, ext_cs_rom, ext_cs_xram, ext_cs_wram;
	byte_t ext_din;

	integer    seed = 32'h1a709654;
	addr_t     seen_adr;    // Bus as it was while the last CPU strobe was high
	byte_t     seen_dout;
	logic      seen_rd, seen_wr, seen_rom, seen_xram, seen_wram;
	vram_adr_t vram_seen [$];
	oam_adr_t  oam_seen [$];
	int        tests;

	`include "tb_models.svh"

	gb_bus_top dut (.*);

	assign ext_din = ext_rule(ext_adr);

	always #(PERIOD / 2) gbclk = ~gbclk;

	task automatic cpu_read(input addr_t a, output byte_t d);
		@(posedge gbclk);
		cpu_adr <= a;
		cpu_rd  <= 1'b1;
		@(negedge gbclk);
		seen_adr  = ext_adr;
		seen_rd   = ext_rd;
		seen_rom  = ext_cs_rom;
		seen_xram = ext_cs_xram;
		seen_wram = ext_cs_wram;
		@(posedge gbclk);
		cpu_rd <= 1'b0;
		@(negedge gbclk);
		d = cpu_din;
	endtask

	task automatic cpu_write(input addr_t a, input byte_t d);
		@(posedge gbclk);
		cpu_adr  <= a;
		cpu_dout <= d;
		cpu_wr   <= 1'b1;
		@(negedge gbclk);
		seen_adr  = ext_adr;
		seen_dout = ext_dout;
		seen_rd   = ext_rd;
		seen_wr   = ext_wr;
		seen_rom  = ext_cs_rom;
		seen_xram = ext_cs_xram;
		seen_wram = ext_cs_wram;
		@(posedge gbclk);
		cpu_wr <= 1'b0;
	endtask

	task automatic ppu_read(input addr_t a, output byte_t d);
		@(posedge gbclk);
		ppu_adr <= a;
		ppu_rd  <= 1'b1;
		@(posedge gbclk);
		ppu_rd <= 1'b0;
		@(negedge gbclk);
		d = ppu_data;
	endtask

	task automatic hold_ppu(input logic need_vram, input logic need_oam);
		@(posedge gbclk);
		ppu_need_vram <= need_vram;
		ppu_need_oam  <= need_oam;
	endtask

	// Cycles with the copy running, bounded so a stuck DMA shows up as a count
	task automatic dma_cycles(output int n);
		n = 0;
		@(negedge gbclk);
		while (dut.dma_active && n < 400) begin
			n++;
			@(negedge gbclk);
		end
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = 0;
		tests++;
	endtask

	task automatic end_test();
		$display("%s done, %0d errors", test_name, test_errors);
	endtask

	task automatic decode_and_open_bus();
		logic [31:0] r;
		addr_t       a;
		byte_t       d;
		int          region;
		begin_test("decode");
		repeat (200) begin
			r = $random(seed);
			a = r[15:0];
			if (r[17:16] == 2'b00)
				a[15:9] = 7'h7f;    // OAM, unusable and IO
			region = region_of(a);
			cpu_read(a, d);
			check_flag("ext_rd", is_ext(region), seen_rd);
			check_flag("cs_rom", region == REG_ROM, seen_rom);
			check_flag("cs_xram", region == REG_XRAM, seen_xram);
			check_flag("cs_wram", region == REG_WRAM, seen_wram);
			if (is_ext(region)) begin
				check_addr("ext_adr", a, seen_adr);
				check_byte("cpu_din", ext_rule(a), d);
				cpu_write(a, r[31:24]);
				check_flag("ext_wr", 1'b1, seen_wr);
				check_flag("ext_rd on write", 1'b0, seen_rd);
				check_addr("ext_adr on write", a, seen_adr);
				check_byte("ext_dout", r[31:24], seen_dout);
				check_flag("cs_rom on write", region == REG_ROM, seen_rom);
				check_flag("cs_xram on write", region == REG_XRAM, seen_xram);
				check_flag("cs_wram on write", region == REG_WRAM, seen_wram);
			end else if (region == REG_NONE) begin
				check_byte("cpu_din open bus", OPEN_BUS, d);
			end
		end
		end_test();
	endtask

	task automatic onchip_memory();
		logic [31:0] r;
		vram_adr_t   va;
		oam_adr_t    oa;
		byte_t       d;
		begin_test("onchip");
		repeat (32) begin
			r  = $random(seed);
			va = r[12:0];
			oa = 8'(r[15:0] % 16'd160);
			vram_m[va] = r[23:16];
			cpu_write({3'b100, va}, r[23:16]);
			oam_m[oa] = r[31:24];
			cpu_write({8'hfe, oa}, r[31:24]);
			vram_seen.push_back(va);
			oam_seen.push_back(oa);
		end
		foreach (vram_seen[i]) begin
			cpu_read({3'b100, vram_seen[i]}, d);
			check_byte("vram", vram_m[vram_seen[i]], d);
			cpu_read({8'hfe, oam_seen[i]}, d);
			check_byte("oam", oam_m[oam_seen[i]], d);
		end
		end_test();
	endtask

	task automatic ppu_priority();
		logic [31:0] r;
		vram_adr_t   va;
		oam_adr_t    oa;
		byte_t       d;
		vram_adr_t   vram_dropped [$];
		oam_adr_t    oam_dropped [$];
		begin_test("ppu");
		hold_ppu(1'b1, 1'b0);
		repeat (20) begin
			r  = $random(seed);
			va = vram_seen[r[4:0]];
			cpu_write({3'b100, va}, ~vram_m[va]);  // Refused
			vram_dropped.push_back(va);
			ppu_read({3'b000, va}, d);
			check_byte("ppu vram", vram_m[va], d);
			cpu_read({3'b100, va}, d);
			check_byte("cpu vram refused", OPEN_BUS, d);
		end
		hold_ppu(1'b0, 1'b1);
		repeat (20) begin
			r  = $random(seed);
			oa = oam_seen[r[4:0]];
			cpu_write({8'hfe, oa}, ~oam_m[oa]);
			oam_dropped.push_back(oa);
			ppu_read({8'h00, oa}, d);
			check_byte("ppu oam", oam_m[oa], d);
			cpu_read({8'hfe, oa}, d);
			check_byte("cpu oam refused", OPEN_BUS, d);
		end
		hold_ppu(1'b0, 1'b0);
		// Dropped writes must not show up once the PPU lets go
		foreach (vram_dropped[i]) begin
			cpu_read({3'b100, vram_dropped[i]}, d);
			check_byte("vram after ppu", vram_m[vram_dropped[i]], d);
			cpu_read({8'hfe, oam_dropped[i]}, d);
			check_byte("oam after ppu", oam_m[oam_dropped[i]], d);
		end
		end_test();
	endtask

	task automatic copy_from_ext();
		logic [31:0] r;
		byte_t       page, d;
		int          n, i;
		begin_test("dma ext");
		r    = $random(seed);
		page = r[7:0];
		if ((page >= 8'h80 && page <= 8'h9f) || page >= 8'he0)
			page = page ^ 8'h40;    // Keeps the source on the external bus
		cpu_write(16'hff46, page);
		fork
			begin
				dma_cycles(n);
				check_count("dma_active cycles", 161, n);
			end
			repeat (20) begin
				r = $random(seed);
				cpu_read({8'hfe, 8'(r[15:0] % 16'd160)}, d);
				check_byte("cpu oam during dma", OPEN_BUS, d);
			end
		join
		for (i = 0; i < 160; i++) begin
			oam_m[i] = page ^ 8'(i);
			cpu_read({8'hfe, 8'(i)}, d);
			check_byte("oam copy", oam_m[i], d);
		end
		end_test();
	endtask

	task automatic copy_from_vram();
		logic [31:0] r;
		byte_t       page, d;
		vram_adr_t   va;
		addr_t       a;
		int          n, i;
		begin_test("dma vram");
		r    = $random(seed);
		page = {3'b100, r[4:0]};
		for (i = 0; i < 160; i++) begin
			r  = $random(seed);
			va = {page[4:0], 8'(i)};
			vram_m[va] = r[7:0];
			cpu_write({3'b100, va}, r[7:0]);
		end
		cpu_write(16'hff46, page);
		fork
			begin
				dma_cycles(n);
				check_count("dma_active cycles", 161, n);
			end
			repeat (20) begin
				r = $random(seed);
				a = r[15:0];
				if (!is_ext(region_of(a)))
					a[15:14] = 2'b00;
				cpu_read(a, d);
				check_byte("cpu ext during dma", ext_rule(a), d);
			end
		join
		for (i = 0; i < 160; i++) begin
			oam_m[i] = vram_m[{page[4:0], 8'(i)}];
			cpu_read({8'hfe, 8'(i)}, d);
			check_byte("oam copy", oam_m[i], d);
		end
		end_test();
	endtask

	initial begin
		rst           <= 1'b1;
		cpu_adr       <= '0;
		cpu_dout      <= '0;
		cpu_rd        <= 1'b0;
		cpu_wr        <= 1'b0;
		ppu_need_vram <= 1'b0;
		ppu_need_oam  <= 1'b0;
		ppu_adr       <= '0;
		ppu_rd        <= 1'b0;
		repeat (5) @(posedge gbclk);
		rst <= 1'b0;
		begin_test("reset");
		@(negedge gbclk);
		check_flag("dma_active", 1'b0, dut.dma_active);
		check_flag("ext_rd", 1'b0, ext_rd);
		check_flag("ext_wr", 1'b0, ext_wr);
		check_flag("cs_rom", 1'b0, ext_cs_rom);
		check_flag("cs_xram", 1'b0, ext_cs_xram);
		check_flag("cs_wram", 1'b0, ext_cs_wram);
		check_byte("cpu_din", OPEN_BUS, cpu_din);
		end_test();
		decode_and_open_bus();
		onchip_memory();
		ppu_priority();
		copy_from_ext();
		copy_from_vram();
		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		$display("Watchdog ran out after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+tests
verilog/gb_pkg.sv
verilog/gb_memmap.sv
verilog/oam_dma.sv
verilog/video_ram.sv
verilog/video_arbiter.sv
verilog/ext_bus_port.sv
verilog/cpu_read_mux.sv
verilog/gb_bus_top.sv
tests/tb_gb_bus.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_gb_bus -f build.f

out=$(./obj_dir/Vtb_gb_bus)
echo "$out"

if echo "$out" | grep -qxF "=== PASS ==="; then
	exit 0
fi
exit 1
